// File: hdl/rf_cfg_pkg.sv
package rf_cfg_pkg;

    localparam int xlen     = 32;
    localparam int preg_num = 64;
    localparam int preg_w   = $clog2(preg_num); // 6 bits for 64 registers.

    // issue side.
    localparam int alu_size   = 2;
    localparam int load_srcs  = 1;
    localparam int store_srcs = 2; // address base and store data.

    // read port map: alu src0, alu src1, load, store.
    localparam int load_base  = alu_size * 2;
    localparam int store_base = load_base + load_srcs;
    localparam int read_ports = store_base + store_srcs;

    // writeback: alu ports first, then the load port.
    localparam int load_wb     = alu_size;
    localparam int write_ports = alu_size + 1;

    typedef logic [xlen-1:0]   xlen_t;
    typedef logic [preg_w-1:0] preg_t;

endpackage

// File: hdl/rf_bus_pkg.sv
package rf_bus_pkg;

    // two-source read request, used by alu, csr, mul and store slots.
    typedef struct packed {
        logic              en;
        rf_cfg_pkg::preg_t src0;
        rf_cfg_pkg::preg_t src1;
    } src2_req_t;

    typedef struct packed {
        logic              en;
        rf_cfg_pkg::preg_t src;
    } src1_req_t;

    typedef struct packed {
        logic              valid;
        rf_cfg_pkg::xlen_t data0;
        rf_cfg_pkg::xlen_t data1;
    } src2_rsp_t;

    typedef struct packed {
        logic              valid;
        rf_cfg_pkg::xlen_t data;
    } src1_rsp_t;

    typedef struct packed {
        logic              en;
        rf_cfg_pkg::preg_t rd;
        rf_cfg_pkg::xlen_t res;
    } wb_t;

endpackage

// File: hdl/read_port_mux.sv
module read_port_mux (
    input  logic                  clk,
    input  logic                  arst_n,
    input  rf_bus_pkg::src2_req_t alu_req [rf_cfg_pkg::alu_size],
    input  rf_bus_pkg::src2_req_t csr_req,
    input  rf_bus_pkg::src2_req_t mul_req,
    input  rf_bus_pkg::src1_req_t load_req,
    input  rf_bus_pkg::src2_req_t store_req,
    output logic                  alu_ready [rf_cfg_pkg::alu_size],
    output logic                  rd_en [rf_cfg_pkg::read_ports],
    output rf_cfg_pkg::preg_t     rd_addr [rf_cfg_pkg::read_ports],
    input  rf_cfg_pkg::xlen_t     operand [rf_cfg_pkg::read_ports],
    output rf_bus_pkg::src2_rsp_t alu_rsp [rf_cfg_pkg::alu_size],
    output rf_bus_pkg::src2_rsp_t csr_rsp,
    output rf_bus_pkg::src2_rsp_t mul_rsp,
    output rf_bus_pkg::src1_rsp_t load_rsp,
    output rf_bus_pkg::src2_rsp_t store_rsp
);
    import rf_cfg_pkg::*;
    import rf_bus_pkg::*;

    src2_req_t brw_req [alu_size]; // borrower of each shared alu port.
    logic      nxt_en [read_ports];
    preg_t     nxt_addr [read_ports];
    logic      nxt_brw [alu_size];
    logic      brw_q [alu_size];     // port owned by the borrower last cycle.

    assign brw_req[0] = csr_req;
    assign brw_req[1] = mul_req;

    // borrower has priority, alu slot has to reissue.
    always_comb begin
        for (int i = 0; i < alu_size; i++) begin
            alu_ready[i] = ~brw_req[i].en;
            nxt_brw[i]   = brw_req[i].en;
            if (brw_req[i].en) begin
                nxt_en[i]              = 1'b1;
                nxt_en[alu_size+i]     = 1'b1;
                nxt_addr[i]            = brw_req[i].src0;
                nxt_addr[alu_size+i]   = brw_req[i].src1;
            end else begin
                nxt_en[i]              = alu_req[i].en;
                nxt_en[alu_size+i]     = alu_req[i].en;
                nxt_addr[i]            = alu_req[i].src0;
                nxt_addr[alu_size+i]   = alu_req[i].src1;
            end
        end
        nxt_en[load_base]      = load_req.en;
        nxt_addr[load_base]    = load_req.src;
        nxt_en[store_base]     = store_req.en;
        nxt_addr[store_base]   = store_req.src0;
        nxt_en[store_base+1]   = store_req.en;
        nxt_addr[store_base+1] = store_req.src1;
    end

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            for (int p = 0; p < read_ports; p++) begin
                rd_en[p]   <= 1'b0;
                rd_addr[p] <= '0;
            end
            for (int i = 0; i < alu_size; i++) begin
                brw_q[i] <= 1'b0;
            end
        end else begin
            for (int p = 0; p < read_ports; p++) begin
                rd_en[p]   <= nxt_en[p];
                rd_addr[p] <= nxt_addr[p];
            end
            for (int i = 0; i < alu_size; i++) begin
                brw_q[i] <= nxt_brw[i];
            end
        end
    end

    // slice operands back into the slot responses.
    always_comb begin
        for (int i = 0; i < alu_size; i++) begin
            alu_rsp[i].valid = rd_en[i] & ~brw_q[i];
            alu_rsp[i].data0 = operand[i];
            alu_rsp[i].data1 = operand[alu_size+i];
        end

        csr_rsp.valid = brw_q[0];
        csr_rsp.data0 = operand[0];
        csr_rsp.data1 = operand[alu_size];

        mul_rsp.valid = brw_q[1];
        mul_rsp.data0 = operand[1];
        mul_rsp.data1 = operand[alu_size+1];

        load_rsp.valid = rd_en[load_base];
        load_rsp.data  = operand[load_base];

        store_rsp.valid = rd_en[store_base];
        store_rsp.data0 = operand[store_base];
        store_rsp.data1 = operand[store_base+1];
    end

endmodule

// File: hdl/phys_regfile.sv
module phys_regfile #(
    parameter int read_cnt  = rf_cfg_pkg::read_ports,
    parameter int write_cnt = rf_cfg_pkg::write_ports
) (
    input  logic              clk,
    input  logic              arst_n,
    input  rf_bus_pkg::wb_t   wb [write_cnt],
    input  logic              rd_en [read_cnt],
    input  rf_cfg_pkg::preg_t rd_addr [read_cnt],
    output rf_cfg_pkg::xlen_t file_data [read_cnt]
);
    import rf_cfg_pkg::*;
    import rf_bus_pkg::*;

    xlen_t mem [preg_num];

    // later ports win on equal rd.
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            for (int r = 0; r < preg_num; r++) begin
                mem[r] <= '0;
            end
        end else begin
            for (int w = 0; w < write_cnt; w++) begin
                if (wb[w].en && wb[w].rd != '0) begin
                    mem[wb[w].rd] <= wb[w].res;
                end
            end
        end
    end

    always_comb begin
        for (int i = 0; i < read_cnt; i++) begin
            if (rd_en[i] && rd_addr[i] != '0) begin
                file_data[i] = mem[rd_addr[i]];
            end else begin
                file_data[i] = '0; // idle port or zero register.
            end
        end
    end

endmodule

// File: hdl/wb_bypass.sv
module wb_bypass #(
    parameter int fwd_cnt = rf_cfg_pkg::alu_size
) (
    input  rf_cfg_pkg::preg_t rd_addr [rf_cfg_pkg::read_ports],
    input  rf_cfg_pkg::xlen_t file_data [rf_cfg_pkg::read_ports],
    input  rf_bus_pkg::wb_t   fwd [fwd_cnt],
    output rf_cfg_pkg::xlen_t operand [rf_cfg_pkg::read_ports]
);
    import rf_cfg_pkg::*;
    import rf_bus_pkg::*;

    // ascending scan, so the highest matching port wins.
    always_comb begin
        for (int i = 0; i < read_ports; i++) begin
            operand[i] = file_data[i];
            for (int j = 0; j < fwd_cnt; j++) begin
                if (fwd[j].en && fwd[j].rd == rd_addr[i] && rd_addr[i] != '0) begin
                    operand[i] = fwd[j].res;
                end
            end
        end
    end

endmodule

// File: hdl/reg_read_stage.sv
module reg_read_stage (
    input  logic                  clk,
    input  logic                  arst_n,
    input  rf_bus_pkg::src2_req_t alu_req [rf_cfg_pkg::alu_size],
    input  rf_bus_pkg::src2_req_t csr_req,
    input  rf_bus_pkg::src2_req_t mul_req,
    input  rf_bus_pkg::src1_req_t load_req,
    input  rf_bus_pkg::src2_req_t store_req,
    output logic                  alu_ready [rf_cfg_pkg::alu_size],
    output rf_bus_pkg::src2_rsp_t alu_rsp [rf_cfg_pkg::alu_size],
    output rf_bus_pkg::src2_rsp_t csr_rsp,
    output rf_bus_pkg::src2_rsp_t mul_rsp,
    output rf_bus_pkg::src1_rsp_t load_rsp,
    output rf_bus_pkg::src2_rsp_t store_rsp,
    input  rf_bus_pkg::wb_t       wb [rf_cfg_pkg::write_ports]
);
    import rf_cfg_pkg::*;
    import rf_bus_pkg::*;

    logic  rd_en [read_ports];
    preg_t rd_addr [read_ports];
    xlen_t file_data [read_ports];
    xlen_t operand [read_ports];
    wb_t   alu_fwd [alu_size]; // load writeback is not forwarded.

    for (genvar i = 0; i < alu_size; i++) begin : g_fwd
        assign alu_fwd[i] = wb[i];
    end

    read_port_mux i_mux (
        .clk       (clk),
        .arst_n    (arst_n),
        .alu_req   (alu_req),
        .csr_req   (csr_req),
        .mul_req   (mul_req),
        .load_req  (load_req),
        .store_req (store_req),
        .alu_ready (alu_ready),
        .rd_en     (rd_en),
        .rd_addr   (rd_addr),
        .operand   (operand),
        .alu_rsp   (alu_rsp),
        .csr_rsp   (csr_rsp),
        .mul_rsp   (mul_rsp),
        .load_rsp  (load_rsp),
        .store_rsp (store_rsp)
    );

    phys_regfile #(
        .read_cnt  (read_ports),
        .write_cnt (write_ports)
    ) i_regfile (
        .clk       (clk),
        .arst_n    (arst_n),
        .wb        (wb),
        .rd_en     (rd_en),
        .rd_addr   (rd_addr),
        .file_data (file_data)
    );

    wb_bypass #(
        .fwd_cnt (alu_size)
    ) i_bypass (
        .rd_addr   (rd_addr),
        .file_data (file_data),
        .fwd       (alu_fwd),
        .operand   (operand)
    );

endmodule

// File: tb/reg_read_sva.sv
module reg_read_sva (
    input logic                  clk,
    input logic                  arst_n,
    input rf_bus_pkg::src2_req_t csr_req,
    input rf_bus_pkg::src2_req_t mul_req,
    input rf_bus_pkg::src1_req_t load_req,
    input logic                  alu_ready [rf_cfg_pkg::alu_size],
    input rf_bus_pkg::src2_rsp_t alu_rsp [rf_cfg_pkg::alu_size],
    input rf_bus_pkg::src2_rsp_t csr_rsp,
    input rf_bus_pkg::src2_rsp_t mul_rsp,
    input rf_bus_pkg::src1_rsp_t load_rsp
);

    // a shared alu port is only taken away by its own borrower.
    ready_owner: assert property (
        @(posedge clk) disable iff (!arst_n)
        (alu_ready[0] || csr_req.en) && (alu_ready[1] || mul_req.en)
    ) else $error("alu_ready low without a borrower request");

    load_latency: assert property (
        @(posedge clk) disable iff (!arst_n)
        load_req.en |=> load_rsp.valid
    ) else $error("load request gave no valid response one cycle later");

    one_owner: assert property (
        @(posedge clk) disable iff (!arst_n)
        !(alu_rsp[0].valid && csr_rsp.valid) && !(alu_rsp[1].valid && mul_rsp.valid)
    ) else $error("two slots valid on one shared read port");

endmodule

// File: tb/tb_reg_read.sv
module tb_reg_read;
    import rf_cfg_pkg::*;
    import rf_bus_pkg::*;

    logic      clk;
    logic      arst_n;
    src2_req_t alu_req [alu_size];
    src2_req_t csr_req;
    src2_req_t mul_req;
    src1_req_t load_req;
    src2_req_t store_req;
    wb_t       wb [write_ports];
    logic      alu_ready [alu_size];
    src2_rsp_t alu_rsp [alu_size];
    src2_rsp_t csr_rsp;
    src2_rsp_t mul_rsp;
    src1_rsp_t load_rsp;
    src2_rsp_t store_rsp;

    // next cycle values that are applied just after the clock edge.
    logic      rst_n_d;
    src2_req_t alu_d [alu_size];
    src2_req_t csr_d;
    src2_req_t mul_d;
    src1_req_t load_d;
    src2_req_t store_d;
    wb_t       wb_d [write_ports];

    // reference model of the register contents and the requests taken at the last edge.
    xlen_t     regs [preg_num];
    src2_req_t p_alu [alu_size];
    src2_req_t p_csr;
    src2_req_t p_mul;
    src1_req_t p_load;
    src2_req_t p_store;

    logic [31:0] lfsr_state;
    string       test_name;

    reg_read_stage i_dut (
        .clk       (clk),
        .arst_n    (arst_n),
        .alu_req   (alu_req),
        .csr_req   (csr_req),
        .mul_req   (mul_req),
        .load_req  (load_req),
        .store_req (store_req),
        .alu_ready (alu_ready),
        .alu_rsp   (alu_rsp),
        .csr_rsp   (csr_rsp),
        .mul_rsp   (mul_rsp),
        .load_rsp  (load_rsp),
        .store_rsp (store_rsp),
        .wb        (wb)
    );

    bind reg_read_stage reg_read_sva i_sva (
        .clk       (clk),
        .arst_n    (arst_n),
        .csr_req   (csr_req),
        .mul_req   (mul_req),
        .load_req  (load_req),
        .alu_ready (alu_ready),
        .alu_rsp   (alu_rsp),
        .csr_rsp   (csr_rsp),
        .mul_rsp   (mul_rsp),
        .load_rsp  (load_rsp)
    );

    initial clk = 1'b0;
    always #2 clk = ~clk;

    function automatic logic [31:0] lfsr_step(input logic [31:0] s);
        return s[0] ? ((s >> 1) ^ 32'h8020_0003) : (s >> 1); // taps 32, 22, 2, 1.
    endfunction

    function automatic logic [31:0] rnd(input int n);
        logic [31:0] v;
        v = '0;
        for (int b = 0; b < n; b++) begin
            lfsr_state = lfsr_step(lfsr_state);
            v = {v[30:0], lfsr_state[0]};
        end
        return v;
    endfunction

    function automatic src2_req_t req2(input logic en, input int a, input int b);
        src2_req_t r;
        r.en   = en;
        r.src0 = preg_t'(a);
        r.src1 = preg_t'(b);
        return r;
    endfunction

    function automatic wb_t make_wb(input int rd, input xlen_t res);
        wb_t w;
        w.en  = 1'b1;
        w.rd  = preg_t'(rd);
        w.res = res;
        return w;
    endfunction

    function automatic src2_req_t rand_src2(input int addr_bits, input int en_bits);
        src2_req_t r;
        r.en   = (rnd(en_bits) == 0);
        r.src0 = preg_t'(rnd(addr_bits));
        r.src1 = preg_t'(rnd(addr_bits));
        return r;
    endfunction

    // register value seen by a read in its response cycle.
    function automatic xlen_t model_read(input preg_t a);
        xlen_t v;
        if (a == '0) begin
            return '0;
        end
        v = regs[a];
        if (wb[0].en && wb[0].rd == a) begin
            v = wb[0].res;
        end
        if (wb[1].en && wb[1].rd == a) begin
            v = wb[1].res; // alu port 1 beats port 0 and the load port never forwards.
        end
        return v;
    endfunction

    function automatic logic rsp_valid(input int slot);
        case (slot)
            0:       return alu_rsp[0].valid;
            1:       return alu_rsp[1].valid;
            2:       return csr_rsp.valid;
            3:       return mul_rsp.valid;
            4:       return load_rsp.valid;
            default: return store_rsp.valid;
        endcase
    endfunction

    task automatic stop_on_error();
        $display("Errors found");
        $fatal(1, "simulation stopped at the first error");
    endtask

    task automatic check_bit(input string what, input logic exp, input logic act);
        assert (act === exp) else begin
            $display("ERR %s %s expected %0d actual %0d", test_name, what, exp, act);
            stop_on_error();
        end
    endtask

    task automatic check_word(input string what, input xlen_t exp, input xlen_t act);
        assert (act === exp) else begin
            $display("ERR %s %s expected %08h actual %08h", test_name, what, exp, act);
            stop_on_error();
        end
    endtask

    task automatic check_src2(input string slot, input src2_req_t req, input src2_rsp_t rsp);
        check_bit({slot, " valid"}, req.en, rsp.valid);
        if (req.en) begin
            check_word({slot, " data0"}, model_read(req.src0), rsp.data0);
            check_word({slot, " data1"}, model_read(req.src1), rsp.data1);
        end
    endtask

    task automatic check_outputs();
        check_bit("alu0 ready", !csr_req.en, alu_ready[0]);
        check_bit("alu1 ready", !mul_req.en, alu_ready[1]);
        check_src2("alu0", p_alu[0], alu_rsp[0]);
        check_src2("alu1", p_alu[1], alu_rsp[1]);
        check_src2("csr", p_csr, csr_rsp);
        check_src2("mul", p_mul, mul_rsp);
        check_src2("store", p_store, store_rsp);
        check_bit("load valid", p_load.en, load_rsp.valid);
        if (p_load.en) begin
            check_word("load data", model_read(p_load.src), load_rsp.data);
        end
    endtask

    task automatic update_model();
        if (!arst_n) begin
            for (int r = 0; r < preg_num; r++) begin
                regs[r] = '0;
            end
            p_alu[0] = '0;
            p_alu[1] = '0;
            p_csr    = '0;
            p_mul    = '0;
            p_load   = '0;
            p_store  = '0;
        end else begin
            for (int w = 0; w < write_ports; w++) begin
                if (wb[w].en && wb[w].rd != '0) begin
                    regs[wb[w].rd] = wb[w].res;
                end
            end
            p_alu[0]    = alu_req[0];
            p_alu[0].en = alu_req[0].en && !csr_req.en; // dropped while borrowed.
            p_alu[1]    = alu_req[1];
            p_alu[1].en = alu_req[1].en && !mul_req.en;
            p_csr       = csr_req;
            p_mul       = mul_req;
            p_load      = load_req;
            p_store     = store_req;
        end
    endtask

    task automatic drive_inputs();
        arst_n    = rst_n_d;
        alu_req   = alu_d;
        csr_req   = csr_d;
        mul_req   = mul_d;
        load_req  = load_d;
        store_req = store_d;
        wb        = wb_d;
    endtask

    task automatic idle();
        alu_d[0] = '0;
        alu_d[1] = '0;
        csr_d    = '0;
        mul_d    = '0;
        load_d   = '0;
        store_d  = '0;
        for (int w = 0; w < write_ports; w++) begin
            wb_d[w] = '0;
        end
    endtask

    task automatic cycle();
        @(posedge clk);
        update_model();
        #1;
        drive_inputs();
        @(negedge clk);
        check_outputs();
    endtask

    task automatic wait_valid(input int slot, input int limit);
        int n;
        logic seen;
        n = 0;
        seen = 1'b0;
        while (!seen && n < limit) begin
            cycle();
            idle();
            seen = rsp_valid(slot);
            n++;
        end
        assert (seen) else begin
            $display("timeout: slot %0d gave no response within %0d cycles", slot, limit);
            stop_on_error();
        end
    endtask

    task automatic random_wb(input int addr_bits);
        for (int w = 0; w < write_ports; w++) begin
            wb_d[w].en  = 1'(rnd(1));
            wb_d[w].rd  = preg_t'(rnd(addr_bits));
            wb_d[w].res = rnd(xlen);
        end
        if (wb_d[1].rd == wb_d[0].rd) begin
            wb_d[1].en = 1'b0;
        end
        if (wb_d[2].rd == wb_d[0].rd || wb_d[2].rd == wb_d[1].rd) begin
            wb_d[2].en = 1'b0;
        end
    endtask

    task automatic random_reads(input int addr_bits);
        alu_d[0]    = rand_src2(addr_bits, 1);
        alu_d[1]    = rand_src2(addr_bits, 1);
        csr_d       = rand_src2(addr_bits, 2); // borrowers request less often.
        mul_d       = rand_src2(addr_bits, 2);
        store_d     = rand_src2(addr_bits, 1);
        load_d.en   = 1'(rnd(1));
        load_d.src  = preg_t'(rnd(addr_bits));
    endtask

    initial begin
        lfsr_state = 32'd30;
        test_name  = "reset";
        rst_n_d    = 1'b0;
        idle();
        drive_inputs();
        repeat (10) cycle();
        rst_n_d = 1'b1;
        cycle();

        test_name = "zero_after_reset";
        for (int r = 0; r < preg_num; r++) begin
            alu_d[0]   = req2(1'b1, r, preg_num - 1 - r);
            alu_d[1]   = req2(1'b1, preg_num - 1 - r, r);
            store_d    = req2(1'b1, r, r);
            load_d.en  = 1'b1;
            load_d.src = preg_t'(r);
            cycle();
        end
        idle();
        cycle();

        test_name = "random_rw";
        for (int c = 0; c < 48; c++) begin
            random_wb(preg_w);
            cycle();
        end
        idle();
        alu_d[1] = req2(1'b1, 0, 0);
        csr_d    = req2(1'b1, 0, 1);
        cycle();
        for (int c = 0; c < 48; c++) begin
            random_reads(preg_w);
            cycle();
        end
        idle();
        cycle();

        test_name = "port_conflict";
        alu_d[0] = req2(1'b1, 3, 4);
        csr_d    = req2(1'b1, 5, 6);
        alu_d[1] = req2(1'b1, 7, 8);
        mul_d    = req2(1'b1, 9, 10);
        wait_valid(2, 4);
        check_bit("alu0 dropped", 1'b0, alu_rsp[0].valid);
        check_bit("alu1 dropped", 1'b0, alu_rsp[1].valid);
        check_bit("mul taken", 1'b1, mul_rsp.valid);

        test_name = "forwarding";
        wb_d[2] = make_wb(9, 32'h1111_0009);
        cycle();
        idle();
        alu_d[0] = req2(1'b1, 9, 9);
        cycle();
        idle();
        wb_d[0] = make_wb(9, 32'hAAAA_0000);
        wb_d[1] = make_wb(9, 32'hBBBB_0001);
        wait_valid(0, 4);
        check_word("alu port 1 wins", 32'hBBBB_0001, alu_rsp[0].data0);
        alu_d[0] = req2(1'b1, 9, 9);
        cycle();
        idle();
        wb_d[2] = make_wb(9, 32'hCCCC_0002);
        wait_valid(0, 4);
        check_word("load not forwarded", 32'hBBBB_0001, alu_rsp[0].data0);
        cycle();

        test_name = "random_traffic";
        for (int c = 0; c < 2000; c++) begin
            random_reads(4); // small address range gives frequent forwarding hits.
            random_wb(4);
            cycle();
        end
        idle();
        cycle();

        $display("No errors");
        $finish;
    end

endmodule

// File: sim.f
hdl/rf_cfg_pkg.sv
hdl/rf_bus_pkg.sv
hdl/read_port_mux.sv
hdl/phys_regfile.sv
hdl/wb_bypass.sv
hdl/reg_read_stage.sv
tb/reg_read_sva.sv
tb/tb_reg_read.sv

// File: run_sim.sh
#!/usr/bin/env bash
# build the register read stage testbench with Verilator and run it.

cd "$(dirname "$0")" || exit 1

build_dir=obj_dir
log_file=sim.log

verilator --binary --timing --assert -f sim.f --top-module tb_reg_read \
    -Mdir "$build_dir" -o sim_tb
if [ $? -ne 0 ]; then
    echo "verilator build failed"
    exit 1
fi

"./$build_dir/sim_tb" > "$log_file" 2>&1
run_status=$?
cat "$log_file"

if grep -qx "No errors" "$log_file"; then
    echo "simulation passed"
    exit 0
fi

echo "simulation failed, exit status $run_status"
exit 1
